//--- rename_pkg.sv
// Shared widths, bus structs and ROB entry state for the rename slice; referenced by scoped names
package rename_pkg;

    // ----------------------------------------
    // Sizes
    // ----------------------------------------

    // Data path width
    localparam int XLEN       = 32;
    // Architectural register count and index width
    localparam int ARCH_REGS  = 32;
    localparam int REG_ADDR_W = 5;
    // Reorder buffer depth, tag indexes an entry directly
    localparam int ROB_SIZE   = 8;
    localparam int TAG_W      = 3;

    // ----------------------------------------
    // Bus types
    // ----------------------------------------

    // Decoded instruction from the front end
    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic                  rd_we;
    } decode_req_t;

    // One renamed source operand
    // Value is valid when waiting is low, otherwise tag names the producer
    typedef struct packed {
        logic [XLEN-1:0]  value;
        logic [TAG_W-1:0] tag;
        logic             waiting;
    } operand_t;

    // Renamed instruction sent on to issue
    typedef struct packed {
        logic                  valid;
        logic [TAG_W-1:0]      tag;
        logic [REG_ADDR_W-1:0] rd;
        // Already cleared for x0
        logic                  rd_we;
        operand_t              op1;
        operand_t              op2;
    } dispatch_t;

    // Result bus, one broadcast per cycle
    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  data;
    } result_t;

    // Retiring instruction from the ROB head
    typedef struct packed {
        logic                  valid;
        logic [TAG_W-1:0]      tag;
        logic [REG_ADDR_W-1:0] rd;
        logic                  rd_we;
        logic [XLEN-1:0]       data;
    } commit_t;

    // State of one ROB entry
    typedef enum logic [1:0] {
        ROB_FREE    = 2'd0,
        ROB_PENDING = 2'd1,
        ROB_DONE    = 2'd2
    } rob_state_e;

endpackage

//--- arch_reg_file.sv
// Architectural register file: committed state, two combinational reads and one commit write
`timescale 1ns/1ps

module arch_reg_file (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic [rename_pkg::REG_ADDR_W-1:0]   rs1_i,
    input  logic [rename_pkg::REG_ADDR_W-1:0]   rs2_i,
    output logic [rename_pkg::XLEN-1:0]         rd1_data_o,
    output logic [rename_pkg::XLEN-1:0]         rd2_data_o,
    input  rename_pkg::commit_t                 commit_i
);

    // x1..x31, x0 has no storage
    logic [rename_pkg::XLEN-1:0] regs_q [1:rename_pkg::ARCH_REGS-1];

    // Retired results only, speculative values never land here
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 1; i < rename_pkg::ARCH_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (commit_i.valid && commit_i.rd_we && (commit_i.rd != '0)) begin
            regs_q[commit_i.rd] <= commit_i.data;
        end
    end

    // Read ports, x0 hardwired to zero
    assign rd1_data_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
    assign rd2_data_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

endmodule

//--- register_renaming.sv
// Rename stage: map table, snooping PRF and operand fetch for one instruction per cycle
`timescale 1ns/1ps

module register_renaming (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            flush_i,
    input  rename_pkg::decode_req_t         decode_i,
    input  logic                            rob_ready_i,
    input  logic [rename_pkg::TAG_W-1:0]    new_tag_i,
    input  logic [rename_pkg::XLEN-1:0]     rd1_data_i,
    input  logic [rename_pkg::XLEN-1:0]     rd2_data_i,
    input  rename_pkg::result_t             result_i,
    input  rename_pkg::commit_t             commit_i,
    output rename_pkg::dispatch_t           dispatch_o
);

    // ----------------------------------------
    // State
    // ----------------------------------------

    // Map table, busy means an in-flight producer owns the register
    logic [rename_pkg::ARCH_REGS-1:0]                        map_busy_q;
    logic [rename_pkg::ARCH_REGS-1:0]                        map_busy_d;
    logic [rename_pkg::ARCH_REGS-1:0][rename_pkg::TAG_W-1:0] map_tag_q;
    logic [rename_pkg::ARCH_REGS-1:0][rename_pkg::TAG_W-1:0] map_tag_d;

    // PRF indexed by ROB tag, filled from the result bus
    logic [rename_pkg::XLEN-1:0]     prf_data_q [rename_pkg::ROB_SIZE];
    logic [rename_pkg::ROB_SIZE-1:0] prf_ready_q;
    logic [rename_pkg::ROB_SIZE-1:0] prf_ready_d;

    // Producer tags currently mapped to each source
    logic [rename_pkg::TAG_W-1:0] rs1_tag;
    logic [rename_pkg::TAG_W-1:0] rs2_tag;

    // Rename of rd happens this cycle
    logic do_map;

    // ----------------------------------------
    // Operand fetch
    // ----------------------------------------

    // Three-way choice: ARF value, PRF value, or wait on tag
    function automatic rename_pkg::operand_t fetch_operand(
        input logic [rename_pkg::REG_ADDR_W-1:0] rs,
        input logic [rename_pkg::XLEN-1:0]       arch_data,
        input logic                              busy,
        input logic [rename_pkg::TAG_W-1:0]      tag,
        input logic                              tag_ready,
        input logic [rename_pkg::XLEN-1:0]       tag_data
    );
        rename_pkg::operand_t op;
        op = '0;
        if (!busy || (rs == '0)) begin
            // Unmapped, committed value holds
            op.value = arch_data;
        end else if (tag_ready) begin
            // Producer finished but not yet retired
            op.value = tag_data;
        end else begin
            op.tag     = tag;
            op.waiting = 1'b1;
        end
        return op;
    endfunction

    assign rs1_tag = map_tag_q[decode_i.rs1];
    assign rs2_tag = map_tag_q[decode_i.rs2];

    always_comb begin
        // Valid only with a free ROB entry, decode holds otherwise
        dispatch_o.valid = decode_i.valid && rob_ready_i;
        dispatch_o.tag   = new_tag_i;
        dispatch_o.rd    = decode_i.rd;
        // Writes to x0 are dropped here
        dispatch_o.rd_we = decode_i.rd_we && (decode_i.rd != '0);
        dispatch_o.op1   = fetch_operand(decode_i.rs1, rd1_data_i,
                                         map_busy_q[decode_i.rs1], rs1_tag,
                                         prf_ready_q[rs1_tag], prf_data_q[rs1_tag]);
        dispatch_o.op2   = fetch_operand(decode_i.rs2, rd2_data_i,
                                         map_busy_q[decode_i.rs2], rs2_tag,
                                         prf_ready_q[rs2_tag], prf_data_q[rs2_tag]);
    end

    assign do_map = dispatch_o.valid && dispatch_o.rd_we;

    // ----------------------------------------
    // Next state
    // ----------------------------------------

    always_comb begin
        map_busy_d  = map_busy_q;
        map_tag_d   = map_tag_q;
        prf_ready_d = prf_ready_q;

        // Result snoop, visible to operand fetch from the next cycle
        if (result_i.valid) begin
            prf_ready_d[result_i.tag] = 1'b1;
        end

        // Retire frees the mapping only if no younger writer took over
        if (commit_i.valid && commit_i.rd_we &&
            map_busy_q[commit_i.rd] && (map_tag_q[commit_i.rd] == commit_i.tag)) begin
            map_busy_d[commit_i.rd] = 1'b0;
        end

        // New mapping last so it wins over a same-rd commit
        if (do_map) begin
            map_busy_d[dispatch_o.rd] = 1'b1;
            map_tag_d[dispatch_o.rd]  = new_tag_i;
            prf_ready_d[new_tag_i]    = 1'b0;
        end
    end

    // Control state, flush drops every mapping and ready bit
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            map_busy_q  <= '0;
            map_tag_q   <= '0;
            prf_ready_q <= '0;
        end else if (flush_i) begin
            map_busy_q  <= '0;
            map_tag_q   <= '0;
            prf_ready_q <= '0;
        end else begin
            map_busy_q  <= map_busy_d;
            map_tag_q   <= map_tag_d;
            prf_ready_q <= prf_ready_d;
        end
    end

    // PRF payload
    always_ff @(posedge clk_i) begin
        if (result_i.valid) begin
            prf_data_q[result_i.tag] <= result_i.data;
        end
    end

endmodule

//--- reorder_buffer.sv
// Reorder buffer: allocates tags on dispatch, records results and retires the head in order
`timescale 1ns/1ps

module reorder_buffer (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            flush_i,
    input  rename_pkg::dispatch_t           dispatch_i,
    input  rename_pkg::result_t             result_i,
    output logic                            rob_ready_o,
    output logic [rename_pkg::TAG_W-1:0]    new_tag_o,
    output rename_pkg::commit_t             commit_o
);

    // ----------------------------------------
    // Storage
    // ----------------------------------------

    // Entry state, the only per-entry control
    rename_pkg::rob_state_e state_q [rename_pkg::ROB_SIZE];

    // Entry payload
    logic [rename_pkg::REG_ADDR_W-1:0] rd_q    [rename_pkg::ROB_SIZE];
    logic                              rd_we_q [rename_pkg::ROB_SIZE];
    logic [rename_pkg::XLEN-1:0]       data_q  [rename_pkg::ROB_SIZE];

    // Ring pointers, wrap naturally with a power-of-two depth
    logic [rename_pkg::TAG_W-1:0] head_q;
    logic [rename_pkg::TAG_W-1:0] tail_q;
    // One extra bit so a full ring is distinct from empty
    logic [rename_pkg::TAG_W:0]   count_q;
    logic [rename_pkg::TAG_W:0]   count_d;

    logic alloc;
    logic retire;
    logic result_hit;

    // ----------------------------------------
    // Control
    // ----------------------------------------

    assign rob_ready_o = (count_q != rename_pkg::ROB_SIZE);
    // Next instruction takes the tail slot
    assign new_tag_o   = tail_q;

    // Rename stage already gated valid with rob_ready_o
    assign alloc  = dispatch_i.valid;
    assign retire = commit_o.valid;

    // Stale results for freed entries are ignored
    assign result_hit = result_i.valid && (state_q[result_i.tag] == rename_pkg::ROB_PENDING);

    assign count_d = count_q + {{rename_pkg::TAG_W{1'b0}}, alloc}
                             - {{rename_pkg::TAG_W{1'b0}}, retire};

    // Head retires once its result is in
    always_comb begin
        commit_o.valid = (state_q[head_q] == rename_pkg::ROB_DONE);
        commit_o.tag   = head_q;
        commit_o.rd    = rd_q[head_q];
        commit_o.rd_we = rd_we_q[head_q];
        commit_o.data  = data_q[head_q];
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < rename_pkg::ROB_SIZE; i++) begin
                state_q[i] <= rename_pkg::ROB_FREE;
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            // Drop everything in flight
            for (int i = 0; i < rename_pkg::ROB_SIZE; i++) begin
                state_q[i] <= rename_pkg::ROB_FREE;
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            // Result targets a pending entry, never the retiring head
            if (result_hit) begin
                state_q[result_i.tag] <= rename_pkg::ROB_DONE;
            end
            if (retire) begin
                state_q[head_q] <= rename_pkg::ROB_FREE;
                head_q          <= head_q + 1'b1;
            end
            // Tail equals head only when empty or full, so no clash with retire
            if (alloc) begin
                state_q[tail_q] <= rename_pkg::ROB_PENDING;
                tail_q          <= tail_q + 1'b1;
            end
            count_q <= count_d;
        end
    end

    // ----------------------------------------
    // Payload
    // ----------------------------------------

    always_ff @(posedge clk_i) begin
        if (alloc) begin
            rd_q[tail_q]    <= dispatch_i.rd;
            rd_we_q[tail_q] <= dispatch_i.rd_we;
        end
        if (result_hit) begin
            data_q[result_i.tag] <= result_i.data;
        end
    end

endmodule

//--- ooo_rename_top.sv
// Top level of the rename and retirement slice: rename stage, ROB and architectural file
`timescale 1ns/1ps

module ooo_rename_top (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        flush_i,
    input  rename_pkg::decode_req_t     decode_i,
    input  rename_pkg::result_t         result_i,
    output rename_pkg::dispatch_t       dispatch_o,
    output rename_pkg::commit_t         commit_o
);

    // ----------------------------------------
    // Internal wires
    // ----------------------------------------

    // ROB to rename
    logic                         rob_ready;
    logic [rename_pkg::TAG_W-1:0] new_tag;

    // ARF reads at rs1 and rs2
    logic [rename_pkg::XLEN-1:0]  rd1_data;
    logic [rename_pkg::XLEN-1:0]  rd2_data;

    // ----------------------------------------
    // Instances
    // ----------------------------------------

    register_renaming u_rename (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .flush_i     (flush_i),
        .decode_i    (decode_i),
        .rob_ready_i (rob_ready),
        .new_tag_i   (new_tag),
        .rd1_data_i  (rd1_data),
        .rd2_data_i  (rd2_data),
        .result_i    (result_i),
        .commit_i    (commit_o),
        .dispatch_o  (dispatch_o)
    );

    // Allocation follows the dispatch valid bit
    reorder_buffer u_rob (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .flush_i     (flush_i),
        .dispatch_i  (dispatch_o),
        .result_i    (result_i),
        .rob_ready_o (rob_ready),
        .new_tag_o   (new_tag),
        .commit_o    (commit_o)
    );

    // Flush does not reach committed state
    arch_reg_file u_arf (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .rs1_i       (decode_i.rs1),
        .rs2_i       (decode_i.rs2),
        .rd1_data_o  (rd1_data),
        .rd2_data_o  (rd2_data),
        .commit_i    (commit_o)
    );

endmodule

//--- ooo_rename_properties.sv
// ROB occupancy and commit assertions, attached to every reorder_buffer instance through bind
`timescale 1ns/1ps

module ooo_rename_properties (
    input logic                         clk_i,
    input logic                         rst_ni,
    input logic                         commit_valid_i,
    input logic                         alloc_i,
    input logic                         rob_ready_i,
    input logic [rename_pkg::TAG_W:0]   count_i
);

    // Head can only retire from a non-empty ring
    commit_needs_entry: assert property (
        @(posedge clk_i) disable iff (!rst_ni) commit_valid_i |-> (count_i != '0)
    ) else $error("commit valid while the ROB is empty");

    // Occupancy bounded by the ring depth
    count_in_range: assert property (
        @(posedge clk_i) disable iff (!rst_ni) count_i <= rename_pkg::ROB_SIZE
    ) else $error("ROB count above its depth");

    // Allocation only with a free entry
    alloc_when_ready: assert property (
        @(posedge clk_i) disable iff (!rst_ni) alloc_i |-> rob_ready_i
    ) else $error("ROB allocated an entry while not ready");

endmodule

bind reorder_buffer ooo_rename_properties u_props (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .commit_valid_i (commit_o.valid),
    .alloc_i        (alloc),
    .rob_ready_i    (rob_ready_o),
    .count_i        (count_q)
);

//--- ooo_rename_checker.sv
// Reference model of rename and retirement that the testbench top instantiates to compare DUT ports
`timescale 1ns/1ps

module ooo_rename_checker (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    flush_i,
    input  rename_pkg::decode_req_t decode_i,
    input  rename_pkg::result_t     result_i,
    input  rename_pkg::dispatch_t   dispatch_i,
    input  rename_pkg::commit_t     commit_i,
    output int                      checks_o,
    output int                      errors_o
);

    // Model map table and committed registers
    logic                              busy     [rename_pkg::ARCH_REGS];
    logic [rename_pkg::TAG_W-1:0]      map_tag  [rename_pkg::ARCH_REGS];
    logic [rename_pkg::XLEN-1:0]       arch     [rename_pkg::ARCH_REGS];
    // Result seen, its value and the destination per tag
    logic                              done     [rename_pkg::ROB_SIZE];
    logic [rename_pkg::XLEN-1:0]       val      [rename_pkg::ROB_SIZE];
    logic [rename_pkg::REG_ADDR_W-1:0] dest     [rename_pkg::ROB_SIZE];
    logic                              dest_we  [rename_pkg::ROB_SIZE];
    // In-flight tags with the oldest first
    logic [rename_pkg::TAG_W-1:0]      order    [$];
    logic [rename_pkg::TAG_W-1:0]      tail;
    int check_cnt = 0;
    int err_cnt   = 0;

    assign checks_o = check_cnt;
    assign errors_o = err_cnt;

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        check_cnt++;
        if (exp !== act) begin
            err_cnt++;
            $display("CHECK FAILED time %0t: %s expected %0h actual %0h", $time, name, exp, act);
        end
    endtask

    // Unmapped or x0 reads ARF, finished producer gives its value, else wait on tag
    function automatic rename_pkg::operand_t expected_operand(
        input logic [rename_pkg::REG_ADDR_W-1:0] rs
    );
        rename_pkg::operand_t op;
        op = '0;
        if (rs == '0 || !busy[rs]) begin
            op.value = arch[rs];
        end else if (done[map_tag[rs]]) begin
            op.value = val[map_tag[rs]];
        end else begin
            op.tag     = map_tag[rs];
            op.waiting = 1'b1;
        end
        return op;
    endfunction

    // Oldest entry retires once its result is in
    function automatic rename_pkg::commit_t expected_commit();
        rename_pkg::commit_t c;
        c = '0;
        if (order.size() != 0 && done[order[0]]) begin
            c.valid = 1'b1;
            c.tag   = order[0];
            c.rd    = dest[order[0]];
            c.rd_we = dest_we[order[0]];
            c.data  = val[order[0]];
        end
        return c;
    endfunction

    task automatic check_operand(input string name, input rename_pkg::operand_t exp,
                                 input rename_pkg::operand_t act);
        compare({name, ".waiting"}, exp.waiting, act.waiting);
        if (exp.waiting) begin
            compare({name, ".tag"}, exp.tag, act.tag);
        end else begin
            compare({name, ".value"}, exp.value, act.value);
        end
    endtask

    // Flush and reset both drop speculative state
    task automatic clear_speculative();
        foreach (busy[i]) begin
            busy[i] = 1'b0;
        end
        foreach (done[i]) begin
            done[i] = 1'b0;
        end
        order.delete();
        tail = '0;
    endtask

    // ----------------------------------------
    // Compare, then advance the model
    // ----------------------------------------

    // Inputs and combinational outputs are settled at the falling edge
    always @(negedge clk_i) begin : cycle_check
        rename_pkg::commit_t cm;
        logic                disp;
        if (!rst_ni) begin
            clear_speculative();
            foreach (arch[i]) begin
                arch[i] = '0;
            end
        end else begin
            disp = decode_i.valid && (order.size() < rename_pkg::ROB_SIZE);
            compare("dispatch_o.valid", disp, dispatch_i.valid);
            if (disp && dispatch_i.valid) begin
                compare("dispatch_o.tag", tail, dispatch_i.tag);
                compare("dispatch_o.rd", decode_i.rd, dispatch_i.rd);
                compare("dispatch_o.rd_we", decode_i.rd_we && (decode_i.rd != '0),
                        dispatch_i.rd_we);
                check_operand("dispatch_o.op1", expected_operand(decode_i.rs1), dispatch_i.op1);
                check_operand("dispatch_o.op2", expected_operand(decode_i.rs2), dispatch_i.op2);
            end
            cm = expected_commit();
            compare("commit_o.valid", cm.valid, commit_i.valid);
            if (cm.valid && commit_i.valid) begin
                compare("commit_o.tag", cm.tag, commit_i.tag);
                compare("commit_o.rd", cm.rd, commit_i.rd);
                compare("commit_o.rd_we", cm.rd_we, commit_i.rd_we);
                compare("commit_o.data", cm.data, commit_i.data);
            end
            // Commit lands in ARF even on a flush edge
            if (cm.valid) begin
                if (cm.rd_we && cm.rd != '0) begin
                    arch[cm.rd] = cm.data;
                end
                if (cm.rd_we && busy[cm.rd] && map_tag[cm.rd] == cm.tag) begin
                    busy[cm.rd] = 1'b0;
                end
                void'(order.pop_front());
            end
            if (flush_i) begin
                clear_speculative();
            end else begin
                if (result_i.valid) begin
                    done[result_i.tag] = 1'b1;
                    val[result_i.tag]  = result_i.data;
                end
                // Dispatch last so a new mapping wins over a same-rd commit
                if (disp) begin
                    order.push_back(tail);
                    dest[tail]    = decode_i.rd;
                    dest_we[tail] = decode_i.rd_we && (decode_i.rd != '0);
                    done[tail]    = 1'b0;
                    if (dest_we[tail]) begin
                        busy[decode_i.rd]    = 1'b1;
                        map_tag[decode_i.rd] = tail;
                    end
                    tail = tail + 1'b1;
                end
            end
        end
    end

endmodule

//--- tb_ooo_rename.sv
// Testbench top: clock, reset, LFSR stimulus for the rename slice, watchdog and final report
`timescale 1ns/1ps

module tb_ooo_rename;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    flush;
    rename_pkg::decode_req_t decode;
    rename_pkg::result_t     result;
    rename_pkg::dispatch_t   dispatch;
    rename_pkg::commit_t     commit;

    // Dispatched tags still owed a result
    logic [rename_pkg::TAG_W-1:0] pending [$];
    // Instructions in the ROB as seen from the ports
    int inflight = 0;
    int tb_errors = 0;
    int err_mark = 0;
    int checks;
    int check_errors;
    logic [31:0] lfsr = 32'h5926;
    logic [31:0] bits;

    // Cycle budget per test, in test order
    int test_len [6] = '{80, 80, 100, 100, 100, 700};

    always #4 clk = ~clk;

    ooo_rename_top u_dut (
        .clk_i      (clk),
        .rst_ni     (rst_n),
        .flush_i    (flush),
        .decode_i   (decode),
        .result_i   (result),
        .dispatch_o (dispatch),
        .commit_o   (commit)
    );

    ooo_rename_checker u_checker (
        .clk_i      (clk),
        .rst_ni     (rst_n),
        .flush_i    (flush),
        .decode_i   (decode),
        .result_i   (result),
        .dispatch_i (dispatch),
        .commit_i   (commit),
        .checks_o   (checks),
        .errors_o   (check_errors)
    );

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // Observe at the falling edge, drive again 1 ns after the rising edge
    task automatic step();
        logic fired;
        @(negedge clk);
        fired = dispatch.valid;
        if (flush) begin
            pending.delete();
            inflight = 0;
        end else begin
            if (dispatch.valid) begin
                pending.push_back(dispatch.tag);
                inflight++;
            end
            if (commit.valid) begin
                inflight--;
            end
        end
        @(posedge clk);
        #1;
        // A stalled instruction stays on decode
        if (fired) begin
            decode.valid = 1'b0;
        end
        result = '0;
        flush  = 1'b0;
    endtask

    task automatic send(input int rs1, input int rs2, input int rd, input logic we);
        decode = {1'b1, rs1[4:0], rs2[4:0], rd[4:0], we};
        step();
    endtask

    // Result for the idx-th oldest tag without one
    task automatic finish_tag(input int idx, input logic [31:0] data);
        result = {1'b1, pending[idx], data};
        pending.delete(idx);
    endtask

    task automatic drain(input int limit);
        int n;
        n = 0;
        while ((inflight != 0 || decode.valid) && n < limit) begin
            if (pending.size() != 0) begin
                finish_tag(0, take_bits(32));
            end
            step();
            n++;
        end
        if (inflight != 0 || decode.valid) begin
            $display("ROB did not drain within %0d cycles", limit);
            tb_errors++;
        end
    endtask

    task automatic wait_dispatch(input int limit);
        int n;
        n = 0;
        while (decode.valid && n < limit) begin
            step();
            n++;
        end
        if (decode.valid) begin
            $display("Held instruction was not dispatched within %0d cycles", limit);
            tb_errors++;
        end
    endtask

    task automatic end_test(input string name);
        int errs;
        errs     = check_errors + tb_errors - err_mark;
        err_mark = check_errors + tb_errors;
        $display("%-16s %s, %0d errors", name, (errs == 0) ? "passed" : "FAILED", errs);
    endtask

    initial begin
        rst_n  = 1'b0;
        flush  = 1'b0;
        decode = '0;
        result = '0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Fresh state, zero operands and no commit without results
        send(1, 2, 3, 1'b1);
        send(4, 5, 6, 1'b1);
        send(0, 7, 0, 1'b1);
        repeat (3) step();
        drain(64);
        end_test("reset_state");

        // Chain x1 -> x2 -> x3, youngest finishes first and is read from the PRF
        send(8, 9, 1, 1'b1);
        send(1, 1, 2, 1'b1);
        send(2, 1, 3, 1'b1);
        finish_tag(2, 32'hc0de_0003);
        step();
        send(3, 2, 4, 1'b1);
        drain(64);
        end_test("dependent_chain");

        // Shuffled results, then reads of the retired registers
        for (int r = 5; r <= 10; r++) begin
            send(r + 6, r - 4, r, 1'b1);
        end
        while (pending.size() != 0) begin
            finish_tag(take_bits(3) % pending.size(), take_bits(32));
            step();
        end
        drain(64);
        for (int r = 5; r <= 10; r++) begin
            send(r, r + 1, 0, 1'b0);
        end
        drain(64);
        end_test("in_order_retire");

        // Fill the ROB, hold a ninth instruction until the head retires
        for (int i = 0; i < 8; i++) begin
            send(i, i + 1, 12 + i, 1'b1);
        end
        send(20, 21, 22, 1'b1);
        repeat (2) step();
        finish_tag(0, take_bits(32));
        wait_dispatch(16);
        drain(64);
        end_test("back_pressure");

        // Flush with one result in the same cycle
        for (int i = 0; i < 4; i++) begin
            send(23 + i, 0, 11 + i, 1'b1);
        end
        finish_tag(2, take_bits(32));
        flush = 1'b1;
        step();
        for (int i = 0; i < 4; i++) begin
            send(11 + i, 23 + i, 0, 1'b0);
        end
        repeat (4) step();
        drain(64);
        end_test("flush");

        // Random mix, about one flush in 32 cycles
        for (int c = 0; c < 600; c++) begin
            if (!decode.valid && take_bits(1)) begin
                bits   = take_bits(16);
                decode = {1'b1, bits[15:0]};
            end
            if (pending.size() != 0 && take_bits(1)) begin
                finish_tag(take_bits(3) % pending.size(), take_bits(32));
            end
            flush = (take_bits(5) == 0);
            step();
        end
        drain(64);
        end_test("random_mix");

        $display("Totals: %0d checks, %0d errors", checks, check_errors + tb_errors);
        if (check_errors + tb_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog over the summed test budgets plus reset margin
    initial begin
        int budget;
        budget = 0;
        foreach (test_len[i]) begin
            budget += test_len[i];
        end
        #(budget * 8 + 400);
        $display("Watchdog expired, tests did not finish within %0d cycles", budget);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- list.f
rename_pkg.sv
arch_reg_file.sv
register_renaming.sv
reorder_buffer.sv
ooo_rename_top.sv
ooo_rename_properties.sv
ooo_rename_checker.sv
tb_ooo_rename.sv
